/* spi_flash_pkg.sv */
`default_nettype none

package spi_flash_pkg;

    localparam int CLKS_PER_HALF_SCLK = 2;
    localparam int SCLK_CNT_W = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
    localparam int FLASH_ADDR_W = 24;
    localparam int DATA_W = 32;
    localparam int REG_ADDR_W = 3;

    // command word fields.
    localparam int CMD_OPCODE_LSB = 0;
    localparam int CMD_OPCODE_W = 8;
    localparam int CMD_NBITS_LSB = 8;
    localparam int CMD_NBITS_W = 6;
    localparam int CMD_DUMMY_LSB = 16;
    localparam int CMD_DUMMY_W = 4;
    localparam int CMD_ADDR_EN_BIT = 20;

    // transfer word fields.
    localparam int XFER_TYPE_LSB = 0;
    localparam int XFER_TYPE_W = 2;
    localparam int XFER_QUAD_BIT = 2;
    localparam int XFER_W = 3;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_ADDRESS, REG_DATAIN, REG_COMMAND, REG_XFER,
        REG_START, REG_DATAOUT, REG_STATUS, REG_SOFT_RST
    } reg_addr_t;

    typedef enum logic [XFER_TYPE_W-1:0] {
        XFER_CMD   = 2'd0, // opcode only.
        XFER_WRITE = 2'd1,
        XFER_READ  = 2'd2
    } xfer_type_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_OPCODE, ST_ADDR, ST_DUMMY, ST_DATA, ST_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

/* spi_flash_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_regs
    import spi_flash_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [REG_ADDR_W-1:0]   wb_adr,
    input  logic [DATA_W-1:0]       wb_dat_w,
    input  logic [DATA_W-1:0]       dout,
    input  logic                    busy,
    input  logic                    done,
    output logic                    wb_ack,
    output logic [DATA_W-1:0]       wb_dat_r,
    output logic [FLASH_ADDR_W-1:0] flash_addr,
    output logic [DATA_W-1:0]       din,
    output logic [DATA_W-1:0]       command,
    output logic [XFER_W-1:0]       xfer,
    output logic                    sw_start,
    output logic                    soft_rst
);

    logic      access;
    reg_addr_t addr;

    assign access = wb_cyc && wb_stb && !wb_ack; // first cycle of a cycle.
    assign addr   = reg_addr_t'(wb_adr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack     <= 1'b0;
            sw_start   <= 1'b0;
            soft_rst   <= 1'b0;
            flash_addr <= '0;
            din        <= '0;
            command    <= '0;
            xfer       <= '0;
        end else begin
            wb_ack   <= access;
            sw_start <= 1'b0;
            soft_rst <= 1'b0;
            if (access && wb_we) begin
                case (addr)
                    REG_ADDRESS:  flash_addr <= wb_dat_w[FLASH_ADDR_W-1:0];
                    REG_DATAIN:   din <= wb_dat_w;
                    REG_COMMAND:  command <= wb_dat_w;
                    REG_XFER:     xfer <= wb_dat_w[XFER_W-1:0];
                    REG_START:    sw_start <= 1'b1;
                    REG_SOFT_RST: soft_rst <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (addr)
                REG_ADDRESS: wb_dat_r <= DATA_W'(flash_addr);
                REG_DATAIN:  wb_dat_r <= din;
                REG_COMMAND: wb_dat_r <= command;
                REG_XFER:    wb_dat_r <= DATA_W'(xfer);
                REG_DATAOUT: wb_dat_r <= dout;
                REG_STATUS:  wb_dat_r <= {{(DATA_W-2){1'b0}}, busy, done};
                default:     wb_dat_r <= '0; // write-only strobes.
            endcase
        end
    end

endmodule

`default_nettype wire

/* spi_flash_read_port.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_read_port
    import spi_flash_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sw_start,
    input  logic [FLASH_ADDR_W-1:0] flash_addr,
    input  logic [DATA_W-1:0]       command,
    input  logic [XFER_W-1:0]       xfer,
    input  logic                    cache_valid,
    input  logic [FLASH_ADDR_W-1:0] cache_addr,
    input  logic                    xfer_done,
    output logic                    eng_start,
    output logic [FLASH_ADDR_W-1:0] eng_addr,
    output logic [DATA_W-1:0]       eng_command,
    output logic [XFER_W-1:0]       eng_xfer,
    output logic                    cache_ready,
    output logic                    done,
    output logic                    busy
);

    logic eng_busy;
    logic serving_cache;
    logic pending_sw;
    logic launch_cache;
    logic launch_sw;

    // cache wins a tie; its valid is still high in the ready cycle.
    assign launch_cache = !eng_busy && cache_valid && !cache_ready;
    assign launch_sw    = !eng_busy && (sw_start || pending_sw) && !launch_cache;
    assign busy         = eng_busy || pending_sw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eng_start     <= 1'b0;
            eng_busy      <= 1'b0;
            serving_cache <= 1'b0;
            pending_sw    <= 1'b0;
            cache_ready   <= 1'b0;
            done          <= 1'b0;
        end else begin
            eng_start   <= launch_cache || launch_sw;
            cache_ready <= xfer_done && serving_cache;
            if (launch_cache || launch_sw) begin
                eng_busy      <= 1'b1;
                serving_cache <= launch_cache;
            end else if (xfer_done) begin
                eng_busy <= 1'b0;
            end
            if (launch_sw)
                pending_sw <= 1'b0;
            else if (sw_start && (launch_cache || (eng_busy && serving_cache)))
                pending_sw <= 1'b1; // hold until the cache frame ends.
            if (xfer_done && !serving_cache)
                done <= 1'b1;
            else if (launch_sw)
                done <= 1'b0;
        end
    end

    always_comb begin
        eng_addr    = serving_cache ? cache_addr : flash_addr;
        eng_command = command;
        eng_xfer    = xfer;
        if (serving_cache) begin
            eng_command[CMD_NBITS_LSB +: CMD_NBITS_W]   = CMD_NBITS_W'(DATA_W);
            eng_xfer[XFER_TYPE_LSB +: XFER_TYPE_W] = XFER_READ;
        end
    end

endmodule

`default_nettype wire

/* spi_flash_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_ctrl
    import spi_flash_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              soft_rst,
    input  logic              eng_start,
    input  logic [DATA_W-1:0] eng_command,
    input  logic [XFER_W-1:0] eng_xfer,
    input  logic              shift_en,
    input  logic              sample_en,
    output logic              sclk_en,
    output logic              ss,
    output ctrl_state_t       load_sel,
    output logic              quad,
    output logic              data_oe,
    output logic              capture_en,
    output logic              xfer_done
);

    ctrl_state_t            state, next_state, after_state;
    logic [5:0]             bit_cnt;  // sclk periods left in this phase.
    logic [5:0]             phase_len;
    logic [5:0]             data_len;
    logic [CMD_NBITS_W-1:0] nbits;
    logic [CMD_DUMMY_W-1:0] dummy;
    logic                   addr_en;
    logic                   quad_en;
    xfer_type_t             xtype;
    logic                   data_on;

    // frame settings are held for the whole frame.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && eng_start) begin
            nbits   <= eng_command[CMD_NBITS_LSB +: CMD_NBITS_W];
            dummy   <= eng_command[CMD_DUMMY_LSB +: CMD_DUMMY_W];
            addr_en <= eng_command[CMD_ADDR_EN_BIT];
            quad_en <= eng_xfer[XFER_QUAD_BIT];
            xtype   <= xfer_type_t'(eng_xfer[XFER_TYPE_LSB +: XFER_TYPE_W]);
        end
    end

    assign data_len = quad_en ? 6'(nbits >> 2) : 6'(nbits);
    assign data_on  = (xtype != XFER_CMD) && (data_len != '0);

    // next enabled phase after the current one.
    always_comb begin
        after_state = ST_DONE;
        case (state)
            ST_OPCODE: begin
                if (addr_en)             after_state = ST_ADDR;
                else if (dummy != '0)    after_state = ST_DUMMY;
                else if (data_on)        after_state = ST_DATA;
            end
            ST_ADDR: begin
                if (dummy != '0)         after_state = ST_DUMMY;
                else if (data_on)        after_state = ST_DATA;
            end
            ST_DUMMY: if (data_on) after_state = ST_DATA;
            default: after_state = ST_DONE;
        endcase
        case (after_state)
            ST_ADDR:  phase_len = 6'(FLASH_ADDR_W);
            ST_DUMMY: phase_len = 6'(dummy);
            ST_DATA:  phase_len = data_len;
            default:  phase_len = '0;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: if (eng_start) next_state = ST_OPCODE;
            ST_DONE: next_state = ST_IDLE;
            default: begin
                if (after_state == ST_DONE) begin
                    if (sample_en && bit_cnt == 6'd1) next_state = ST_DONE; // last bit in.
                end else if (shift_en && bit_cnt == '0) begin
                    next_state = after_state;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            ss        <= 1'b1;
            xfer_done <= 1'b0;
        end else if (soft_rst) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            ss        <= 1'b1;
            xfer_done <= 1'b0;
        end else begin
            state     <= next_state;
            ss        <= (next_state == ST_IDLE);
            xfer_done <= (state == ST_DONE);
            if (state == ST_IDLE && eng_start)
                bit_cnt <= 6'(CMD_OPCODE_W);
            else if (next_state != state)
                bit_cnt <= phase_len;
            else if (sample_en && bit_cnt != '0)
                bit_cnt <= bit_cnt - 6'd1;
        end
    end

    always_comb begin
        load_sel = ST_IDLE; // no load.
        if (next_state != state && (next_state == ST_OPCODE || next_state == ST_ADDR ||
                (next_state == ST_DATA && xtype == XFER_WRITE)))
            load_sel = next_state;
    end

    assign sclk_en    = (state != ST_IDLE) && (state != ST_DONE);
    assign quad       = (state == ST_DATA) && quad_en;
    assign capture_en = (state == ST_DATA) && (xtype == XFER_READ);
    assign data_oe    = (state != ST_IDLE) && !(quad && xtype == XFER_READ);

endmodule

`default_nettype wire

/* spi_flash_sclk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_sclk_gen
    import spi_flash_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sclk_en,
    output logic sclk,
    output logic shift_en,
    output logic sample_en
);

    logic [SCLK_CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            sclk      <= 1'b0;
            shift_en  <= 1'b0;
            sample_en <= 1'b0;
        end else if (!sclk_en) begin
            cnt       <= '0; // park low between frames.
            sclk      <= 1'b0;
            shift_en  <= 1'b0;
            sample_en <= 1'b0;
        end else if (cnt == SCLK_CNT_W'(CLKS_PER_HALF_SCLK - 1)) begin
            cnt       <= '0;
            sclk      <= ~sclk;
            sample_en <= ~sclk; // rising edge.
            shift_en  <= sclk;  // falling edge.
        end else begin
            cnt       <= cnt + 1'b1;
            shift_en  <= 1'b0;
            sample_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* spi_flash_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_shifter
    import spi_flash_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  ctrl_state_t             load_sel,
    input  logic [DATA_W-1:0]       eng_command,
    input  logic [FLASH_ADDR_W-1:0] eng_addr,
    input  logic [DATA_W-1:0]       din,
    input  logic                    quad,
    input  logic                    data_oe,
    input  logic                    shift_en,
    input  logic                    sample_en,
    input  logic                    capture_en,
    input  logic [3:0]              dq_in,
    output logic [3:0]              dq_out,
    output logic [3:0]              dq_oe,
    output logic [DATA_W-1:0]       dout
);

    logic [DATA_W-1:0]      sr;
    logic [CMD_NBITS_W-1:0] wr_pad;

    // write data of fewer than 32 bits goes out from its top bit.
    assign wr_pad = CMD_NBITS_W'(DATA_W) - eng_command[CMD_NBITS_LSB +: CMD_NBITS_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sr <= '0;
        end else begin
            case (load_sel)
                ST_OPCODE: sr <= {eng_command[CMD_OPCODE_LSB +: CMD_OPCODE_W],
                                  {(DATA_W-CMD_OPCODE_W){1'b0}}};
                ST_ADDR:   sr <= {eng_addr, {(DATA_W-FLASH_ADDR_W){1'b0}}};
                ST_DATA:   sr <= din << wr_pad;
                default: begin
                    if (shift_en) sr <= quad ? sr << 4 : sr << 1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_sel == ST_OPCODE)
            dout <= '0; // new frame.
        else if (sample_en && capture_en)
            dout <= quad ? {dout[DATA_W-5:0], dq_in} : {dout[DATA_W-2:0], dq_in[1]};
    end

    always_comb begin
        if (quad) begin
            dq_out = sr[DATA_W-1 -: 4];
            dq_oe  = {4{data_oe}};
        end else begin
            dq_out = {2'b11, 1'b0, sr[DATA_W-1]}; // hold and wp high.
            dq_oe  = {data_oe, data_oe, 1'b0, 1'b1};
        end
    end

endmodule

`default_nettype wire

/* spi_flash_top.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_top
    import spi_flash_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [REG_ADDR_W-1:0]   wb_adr,
    input  logic [DATA_W-1:0]       wb_dat_w,
    output logic                    wb_ack,
    output logic [DATA_W-1:0]       wb_dat_r,
    input  logic                    cache_valid,
    input  logic [FLASH_ADDR_W-1:0] cache_addr,
    input  logic [3:0]              dq_in,
    output logic                    sclk,
    output logic                    ss,
    output logic [3:0]              dq_out,
    output logic [3:0]              dq_oe,
    output logic                    cache_ready,
    output logic [DATA_W-1:0]       cache_rdata
);

    logic [FLASH_ADDR_W-1:0] flash_addr, eng_addr;
    logic [DATA_W-1:0]       din, command, eng_command;
    logic [XFER_W-1:0]       xfer, eng_xfer;
    logic                    sw_start, soft_rst, eng_rst;
    logic                    busy, done, eng_start, xfer_done;
    logic                    sclk_en, shift_en, sample_en;
    logic                    quad, data_oe, capture_en;
    ctrl_state_t             load_sel;

    assign eng_rst = rst | soft_rst; // soft reset also drops pending requests.

    spi_flash_regs u_regs (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .dout(cache_rdata), .busy, .done, .wb_ack, .wb_dat_r,
        .flash_addr, .din, .command, .xfer, .sw_start, .soft_rst
    );

    spi_flash_read_port u_read_port (
        .clk, .rst(eng_rst), .sw_start, .flash_addr, .command, .xfer,
        .cache_valid, .cache_addr, .xfer_done, .eng_start, .eng_addr,
        .eng_command, .eng_xfer, .cache_ready, .done, .busy
    );

    spi_flash_ctrl u_ctrl (
        .clk, .rst, .soft_rst, .eng_start, .eng_command, .eng_xfer,
        .shift_en, .sample_en, .sclk_en, .ss, .load_sel, .quad,
        .data_oe, .capture_en, .xfer_done
    );

    spi_flash_sclk_gen u_sclk_gen (
        .clk, .rst, .sclk_en, .sclk, .shift_en, .sample_en
    );

    spi_flash_shifter u_shifter (
        .clk, .rst, .load_sel, .eng_command, .eng_addr, .din, .quad,
        .data_oe, .shift_en, .sample_en, .capture_en, .dq_in,
        .dq_out, .dq_oe, .dout(cache_rdata)
    );

endmodule

`default_nettype wire

/* flash_model.sv */
`timescale 1ns/100ps
`default_nettype none

module flash_model (
    input  logic        sclk,
    input  logic        ss,
    input  logic [3:0]  dq,
    input  logic        cfg_addr_en,
    input  logic [3:0]  cfg_dummy,
    input  logic        cfg_quad,
    input  logic        cfg_read,
    output logic [3:0]  drv,
    output logic [3:0]  drv_oe,
    output logic [7:0]  opcode,
    output logic [23:0] addr,
    output logic [31:0] wdata,
    output logic [7:0]  frame_len
);

    logic [7:0] cnt;    // rising sclk edges in this frame.
    logic [7:0] rd_pos; // read bits driven so far.
    logic [7:0] alen;
    logic [7:0] header;
    logic [7:0] cur_byte;

    initial begin
        cnt       = '0;
        rd_pos    = '0;
        drv       = '0;
        drv_oe    = '0;
        frame_len = '0;
    end

    assign alen   = cfg_addr_en ? 8'd24 : 8'd0;
    assign header = 8'd8 + alen + 8'(cfg_dummy);

    // mode 0: sample on the rising edge.
    always @(posedge sclk or posedge ss) begin
        if (ss) begin
            frame_len <= cnt;
            cnt       <= '0;
        end else begin
            if (cnt == 8'd0) begin
                addr  <= '0;
                wdata <= '0;
            end
            if (cnt < 8'd8)
                opcode <= {opcode[6:0], dq[0]};
            else if (cnt < 8'd8 + alen)
                addr <= {addr[22:0], dq[0]};
            else if (cnt >= header)
                wdata <= cfg_quad ? {wdata[27:0], dq} : {wdata[30:0], dq[0]};
            cnt <= cnt + 8'd1;
        end
    end

    // read data goes out on the falling edge, byte a is a[7:0] ^ a5.
    always @(negedge sclk or posedge ss) begin
        if (ss) begin
            drv_oe <= '0;
            rd_pos <= '0;
        end else if (cfg_read && cnt >= header) begin
            cur_byte = 8'(addr + 24'(rd_pos >> 3)) ^ 8'ha5;
            if (cfg_quad) begin
                drv    <= rd_pos[2] ? cur_byte[3:0] : cur_byte[7:4];
                drv_oe <= 4'b1111;
                rd_pos <= rd_pos + 8'd4;
            end else begin
                drv    <= {2'b00, cur_byte[3'd7 - rd_pos[2:0]], 1'b0}; // miso on dq1.
                drv_oe <= 4'b0010;
                rd_pos <= rd_pos + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* spi_flash_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_flash_properties
    import spi_flash_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input ctrl_state_t state,
    input logic        ss,
    input logic        xfer_done,
    input logic        sclk_en
);

    ss_idle_high: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) |-> ss)
        else $error("ss low while the controller is idle");

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        xfer_done |=> !xfer_done)
        else $error("xfer_done longer than one cycle");

    no_sclk_when_deselected: assert property (@(posedge clk) disable iff (rst)
        ss |-> !sclk_en)
        else $error("sclk enabled while ss is high");

endmodule

`default_nettype wire

/* tb_spi_flash.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_spi_flash
    import spi_flash_pkg::*;
;

    localparam int NROWS = 9;

    logic        clk, rst, wb_cyc, wb_stb, wb_we, wb_ack, cache_valid, cache_ready;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r, cache_rdata;
    logic [23:0] cache_addr, m_addr;
    logic        sclk, ss, cfg_addr_en, cfg_quad, cfg_read;
    logic [3:0]  dq_out, dq_oe, dq, m_drv, m_oe, cfg_dummy;
    logic [7:0]  m_opcode, m_frame_len;
    logic [31:0] m_wdata;

    // src: 0 software, 1 cache, 2 cache with a software start during it.
    int          t_src[NROWS], t_len[NROWS];
    logic [23:0] t_adr[NROWS], t_swadr[NROWS], t_exp_addr[NROWS];
    logic [31:0] t_din[NROWS], t_cmd[NROWS], t_exp_data[NROWS];
    logic [2:0]  t_xfer[NROWS];
    logic        t_abort[NROWS];
    int          err_count, limit_cycles, seed;
    logic        table_ready;

    // master wins, then the model, undriven lines float high.
    assign dq = (dq_oe & dq_out) | (~dq_oe & m_oe & m_drv) | (~dq_oe & ~m_oe);

    spi_flash_top u_spi_flash_top (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .wb_dat_r,
        .cache_valid, .cache_addr, .dq_in(dq), .sclk, .ss, .dq_out, .dq_oe,
        .cache_ready, .cache_rdata
    );

    flash_model u_flash (
        .sclk, .ss, .dq, .cfg_addr_en, .cfg_dummy, .cfg_quad, .cfg_read,
        .drv(m_drv), .drv_oe(m_oe), .opcode(m_opcode), .addr(m_addr),
        .wdata(m_wdata), .frame_len(m_frame_len)
    );

    bind spi_flash_ctrl spi_flash_properties u_props (
        .clk, .rst, .state, .ss, .xfer_done, .sclk_en
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] flash_word(input logic [23:0] a);
        return {a[7:0] ^ 8'ha5, 8'(a + 24'd1) ^ 8'ha5, 8'(a + 24'd2) ^ 8'ha5,
                8'(a + 24'd3) ^ 8'ha5};
    endfunction

    // sclk periods: opcode, address, dummy, then data bits or nibbles.
    function automatic int frame_len(input logic [31:0] cmd, input logic [2:0] xf,
                                     input bit cache);
        int n;
        int bits;
        logic [1:0] ty;
        ty   = cache ? 2'd2 : xf[1:0];
        bits = cache ? 32 : int'(cmd[13:8]);
        n    = 8 + (cmd[20] ? 24 : 0) + int'(cmd[19:16]);
        if (ty != 2'd0)
            n = n + (xf[2] ? bits / 4 : bits);
        return n;
    endfunction

    task automatic set_row(input int i, input int src, input logic [23:0] adr,
                           input logic [23:0] swadr, input logic [31:0] cmd,
                           input logic [2:0] xf, input logic abort);
        t_src[i]      = src;
        t_adr[i]      = adr;
        t_swadr[i]    = swadr;
        t_cmd[i]      = cmd;
        t_xfer[i]     = xf;
        t_abort[i]    = abort;
        t_din[i]      = (xf[1:0] == 2'd1) ? $urandom : 32'h0;
        t_exp_addr[i] = adr;
        t_len[i]      = frame_len(cmd, xf, src != 0);
        if (src != 0 || xf[1:0] == 2'd2)
            t_exp_data[i] = flash_word(adr);
        else
            t_exp_data[i] = t_din[i];
    endtask

    task automatic load_table();
        int total;
        set_row(0, 0, 24'h12345c, 24'h0, 32'h0018200b, 3'd2, 1'b0); // single read.
        set_row(1, 0, 24'h000100, 24'h0, 32'h00102002, 3'd1, 1'b0); // single write.
        set_row(2, 0, 24'h000200, 24'h0, 32'h00102032, 3'd5, 1'b0); // quad write.
        set_row(3, 0, 24'h0, 24'h0, 32'h00000006, 3'd0, 1'b0);      // opcode only.
        set_row(4, 0, 24'h00abc0, 24'h0, 32'h0018206b, 3'd6, 1'b0); // quad read.
        set_row(5, 1, 24'h003ff0, 24'h0, 32'h0018200b, 3'd1, 1'b0); // cache, sw says write.
        set_row(6, 2, 24'h004000, 24'h055550, 32'h0018200b, 3'd2, 1'b0);
        set_row(7, 0, 24'h222220, 24'h0, 32'h0018200b, 3'd2, 1'b1); // aborted.
        set_row(8, 0, 24'h222220, 24'h0, 32'h0018200b, 3'd2, 1'b0);
        total = 0;
        for (int i = 0; i < NROWS; i++)
            total = total + 2 * t_len[i] + 40; // row 6 runs two frames.
        limit_cycles = total * 4 + 200;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic wb_access(input logic we, input logic [2:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do tick(); while (!wb_ack);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        do wb_access(1'b0, REG_STATUS, 32'h0, st); while (st[1:0] != 2'b01);
    endtask

    task automatic run_row(input int i);
        logic [31:0] v;
        cfg_addr_en = t_cmd[i][20];
        cfg_dummy   = t_cmd[i][19:16];
        cfg_quad    = t_xfer[i][2];
        cfg_read    = (t_src[i] != 0) || (t_xfer[i][1:0] == 2'd2);
        wb_write(REG_ADDRESS, (t_src[i] == 0) ? t_adr[i] : t_swadr[i]);
        wb_write(REG_DATAIN, t_din[i]);
        wb_write(REG_COMMAND, t_cmd[i]);
        wb_write(REG_XFER, 32'(t_xfer[i]));
        if (t_src[i] == 0) begin
            wb_write(REG_START, 32'h0);
            if (t_abort[i]) begin
                while (ss) tick();
                repeat (20) tick();
                wb_write(REG_SOFT_RST, 32'h0);
                tick();
                check_value("ss after soft reset", ss, 1'b1);
                wb_access(1'b0, REG_STATUS, 32'h0, v);
                check_value("status after soft reset", v, 32'h0);
            end else begin
                wait_done();
                check_value("model opcode", m_opcode, t_cmd[i][7:0]);
                if (t_cmd[i][20])
                    check_value("model address", m_addr, t_exp_addr[i]);
                check_value("frame length", m_frame_len, t_len[i]);
                if (t_xfer[i][1:0] == 2'd1)
                    check_value("model write data", m_wdata, t_exp_data[i]);
                if (t_xfer[i][1:0] == 2'd2) begin
                    wb_access(1'b0, REG_DATAOUT, 32'h0, v);
                    check_value("REG_DATAOUT", v, t_exp_data[i]);
                end
            end
        end else begin
            cache_addr  = t_adr[i];
            cache_valid = 1'b1;
            if (t_src[i] == 2) begin
                while (ss) tick();
                wb_write(REG_START, 32'h0); // held until the cache frame ends.
            end
            do tick(); while (!cache_ready);
            check_value("cache_rdata", cache_rdata, t_exp_data[i]);
            check_value("model address", m_addr, t_adr[i]);
            check_value("frame length", m_frame_len, t_len[i]);
            cache_valid = 1'b0;
            if (t_src[i] == 2) begin
                wait_done();
                wb_access(1'b0, REG_DATAOUT, 32'h0, v);
                check_value("REG_DATAOUT after cache", v, flash_word(t_swadr[i]));
                check_value("model address", m_addr, t_swadr[i]);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        cache_valid = 1'b0;
        cache_addr  = '0;
        cfg_addr_en = 1'b0;
        cfg_dummy   = '0;
        cfg_quad    = 1'b0;
        cfg_read    = 1'b0;
        err_count   = 0;
        table_ready = 1'b0;
        seed        = $urandom(14893);
        load_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        tick();
        check_value("ss", ss, 1'b1);
        check_value("sclk", sclk, 1'b0);
        check_value("cache_ready", cache_ready, 1'b0);
        check_value("dq_oe", dq_oe, 4'b0001); // only dq0 driven when idle.
        begin : reset_status
            logic [31:0] st;
            wb_access(1'b0, REG_STATUS, 32'h0, st);
            check_value("status after reset", st, 32'h0);
        end
        for (int i = 0; i < NROWS; i++)
            run_row(i);
        if (err_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* list.f */
spi_flash_pkg.sv
spi_flash_regs.sv
spi_flash_read_port.sv
spi_flash_ctrl.sv
spi_flash_sclk_gen.sv
spi_flash_shifter.sv
spi_flash_top.sv
flash_model.sv
spi_flash_properties.sv
tb_spi_flash.sv
